/* common/sdp_rdma_pkg.sv */
// shared constants, config encodings and payload structs for the
// sdp read dma request generator; referenced by scoped names only

package sdp_rdma_pkg;

  // ======================================================================
  // atom and field widths
  // ======================================================================

  // one atom is 32 bytes, addresses in atoms drop these bits
  localparam int atom_aw = 5;
  // channel shift for 2-byte precisions, 16 elements per atom
  localparam int atom_aw_16 = 4;
  // cube dimension fields, value is size minus one
  localparam int dim_w = 13;
  // request size in atoms minus one
  localparam int req_size_w = 15;
  // channel atom count, worst case is the 2-byte shift
  localparam int chan_cnt_w = dim_w - atom_aw + 1;

  // ======================================================================
  // config encodings
  // ======================================================================

  // processing precision of the cube
  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1,
    prec_fp16  = 2'd2
  } precision_e;

  // which datapath consumes the operand
  typedef enum logic [1:0] {
    use_mul  = 2'd0,
    use_alu  = 2'd1,
    use_both = 2'd2
  } data_use_e;

  // bytes per element in memory
  typedef enum logic {
    size_1byte = 1'b0,
    size_2byte = 1'b1
  } data_size_e;

  // one operand per kernel or a full cube of operands
  typedef enum logic {
    mode_per_kernel  = 1'b0,
    mode_per_element = 1'b1
  } data_mode_e;

  // ======================================================================
  // structs
  // ======================================================================

  // cube shape and data format, all dims are size minus one
  typedef struct packed {
    logic [dim_w-1:0] channel;
    logic [dim_w-1:0] height;
    logic [dim_w-1:0] width;
    precision_e       precision;
    data_mode_e       data_mode;
    data_size_e       data_size;
    data_use_e        data_use;
  } cube_cfg_t;

  // context queue entry, one per dma request
  typedef struct packed {
    logic                  cube_end;
    logic [req_size_w-1:0] size;
  } cq_req_t;

endpackage

/* logic/stall_counter.sv */
// perf counter of cycles a request waited on the dma port;
// cleared by op_load and frozen while counting is disabled

module stall_counter (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        op_load,
  input  logic        stall,
  input  logic        count_en,
  output logic [31:0] count
);

  // ======================================================================
  // counter
  // ======================================================================

  // clear wins over increment, both need count_en
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count <= '0;
    end else if (count_en) begin
      if (op_load) begin
        count <= '0;
      end else if (stall) begin
        // wraps silently at 2**32
        count <= count + 1'b1;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the request generator testbench with verilator
# exit status is nonzero when the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module tb_sdp_rdma_ig \
  -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb || {
  echo "simulation did not complete successfully"
  exit 1
}

/* sdp_rdma_ig/cube_walker.sv */
// position in the cube walk: active flag, channel and height counters
// and the end flags that steer address and size logic

module cube_walker (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  input  logic                                 op_load,
  input  logic                                 cmd_accept,
  input  sdp_rdma_pkg::cube_cfg_t              cube_cfg,
  input  logic [sdp_rdma_pkg::chan_cnt_w-1:0]  chan_last,
  output logic                                 cmd_process,
  output logic                                 surf_end,
  output logic                                 cube_end,
  output logic                                 straight_mode
);

  logic [sdp_rdma_pkg::chan_cnt_w-1:0] count_c;
  logic [sdp_rdma_pkg::dim_w-1:0]      count_h;
  logic                                mode_per_kernel;
  logic                                mode_1x1_pack;
  logic                                last_c;
  logic                                last_h;
  logic                                op_done;

  // ======================================================================
  // walk shape
  // ======================================================================

  assign mode_per_kernel = (cube_cfg.data_mode == sdp_rdma_pkg::mode_per_kernel);
  // 1x1 surface, the whole cube is one contiguous run
  assign mode_1x1_pack   = (cube_cfg.width == '0) && (cube_cfg.height == '0);
  // single request covers everything
  assign straight_mode   = mode_per_kernel | mode_1x1_pack;

  assign last_h = (count_h == cube_cfg.height);
  assign last_c = (count_c == chan_last);

  // every request is a full line, so line end is always true
  assign surf_end = straight_mode | last_h;
  assign cube_end = straight_mode | (surf_end & last_c);

  assign op_done = cmd_accept & cube_end;

  // ======================================================================
  // operation active
  // ======================================================================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_process <= 1'b0;
    end else if (op_load) begin
      cmd_process <= 1'b1;
    end else if (op_done) begin
      cmd_process <= 1'b0;
    end
  end

  // ======================================================================
  // counters
  // ======================================================================

  // height, one step per accepted line
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (cmd_accept) begin
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // channel atoms, one step per finished surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

endmodule

/* sdp_rdma_ig/req_addr_gen.sv */
// line and surface base addresses of the walk, kept in atoms, and the
// byte address of the current request

module req_addr_gen #(
  parameter int mem_aw = 64
) (
  input  logic                               nvdla_core_clk,
  input  logic                               nvdla_core_rstn,
  input  logic                               op_load,
  input  logic                               cmd_accept,
  input  logic                               surf_end,
  input  logic [31:0]                        base_addr_high,
  input  logic [31:0]                        base_addr_low,
  input  logic [31-sdp_rdma_pkg::atom_aw:0]  line_stride,
  input  logic [31-sdp_rdma_pkg::atom_aw:0]  surf_stride,
  output logic [mem_aw-1:0]                  req_addr
);

  localparam int atom_addr_w = mem_aw - sdp_rdma_pkg::atom_aw;

  logic [atom_addr_w-1:0] cfg_base;
  logic [atom_addr_w-1:0] base_line;
  logic [atom_addr_w-1:0] base_surf;

  // ======================================================================
  // base address in atoms
  // ======================================================================

  generate
    if (mem_aw > 32) begin : g_wide
      logic [63:0] base_cat;

      // high word only matters past 4 GB
      assign base_cat = {base_addr_high, base_addr_low};
      assign cfg_base = base_cat[mem_aw-1:sdp_rdma_pkg::atom_aw];
    end else begin : g_narrow
      assign cfg_base = base_addr_low[mem_aw-1:sdp_rdma_pkg::atom_aw];
    end
  endgenerate

  // ======================================================================
  // stepping
  // ======================================================================

  // next line, or first line of the next surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_line <= '0;
      base_surf <= '0;
    end else if (op_load) begin
      base_line <= cfg_base;
      base_surf <= cfg_base;
    end else if (cmd_accept) begin
      if (surf_end) begin
        base_line <= base_surf + atom_addr_w'(surf_stride);
        base_surf <= base_surf + atom_addr_w'(surf_stride);
      end else begin
        base_line <= base_line + atom_addr_w'(line_stride);
      end
    end
  end

  // back to bytes, always atom aligned
  assign req_addr = {base_line, {sdp_rdma_pkg::atom_aw{1'b0}}};

endmodule

/* sdp_rdma_ig/req_size_calc.sv */
// request size in atoms minus one, from the cube format; also gives the
// channel atom count that bounds the channel loop

module req_size_calc (
  input  sdp_rdma_pkg::cube_cfg_t               cube_cfg,
  input  logic                                  straight_mode,
  output logic [sdp_rdma_pkg::chan_cnt_w-1:0]   chan_last,
  output logic [sdp_rdma_pkg::req_size_w-1:0]   req_size
);

  logic                                  prec_int8;
  logic                                  size_1byte;
  logic                                  use_both;
  logic [1:0]                            scale_sh;
  logic [sdp_rdma_pkg::req_size_w-1:0]   size_of_straight;
  logic [sdp_rdma_pkg::req_size_w-1:0]   size_of_width;

  // count minus one scaled by 2**sh, result is still minus one
  function automatic logic [sdp_rdma_pkg::req_size_w-1:0] scale_cnt(
    input logic [sdp_rdma_pkg::req_size_w-1:0] cnt,
    input logic [1:0]                          sh
  );
    logic [sdp_rdma_pkg::req_size_w-1:0] fill;
    fill = (sdp_rdma_pkg::req_size_w'(1) << sh) - 1'b1;
    return (cnt << sh) + fill;
  endfunction

  assign prec_int8  = (cube_cfg.precision == sdp_rdma_pkg::prec_int8);
  assign size_1byte = (cube_cfg.data_size == sdp_rdma_pkg::size_1byte);
  assign use_both   = (cube_cfg.data_use == sdp_rdma_pkg::use_both);

  // ======================================================================
  // channel atoms
  // ======================================================================

  // int8 packs 32 elements per atom, 16-bit types 16
  always_comb begin
    if (prec_int8) begin
      chan_last = sdp_rdma_pkg::chan_cnt_w'(cube_cfg.channel >> sdp_rdma_pkg::atom_aw);
    end else begin
      chan_last = sdp_rdma_pkg::chan_cnt_w'(cube_cfg.channel >> sdp_rdma_pkg::atom_aw_16);
    end
  end

  // ======================================================================
  // bytes per element
  // ======================================================================

  // int8 1byte single -> x1
  // int8 2byte or both -> x2
  // int8 2byte both -> x4
  // 16-bit single -> x1, both -> x2
  always_comb begin
    if (prec_int8) begin
      if (use_both && !size_1byte) begin
        scale_sh = 2'd2;
      end else if (use_both || !size_1byte) begin
        scale_sh = 2'd1;
      end else begin
        scale_sh = 2'd0;
      end
    end else begin
      scale_sh = use_both ? 2'd1 : 2'd0;
    end
  end

  // ======================================================================
  // request size
  // ======================================================================

  // straight covers all channel atoms in one go
  assign size_of_straight = scale_cnt(sdp_rdma_pkg::req_size_w'(chan_last), scale_sh);
  // otherwise one line of the cube
  assign size_of_width    = scale_cnt(sdp_rdma_pkg::req_size_w'(cube_cfg.width), scale_sh);

  assign req_size = straight_mode ? size_of_straight : size_of_width;

endmodule

/* sdp_rdma_ig/sdp_rdma_ig.sv */
// request side of the sdp read dma: walks the cube after op_load and
// issues one dma read plus a matching context queue entry per step

module sdp_rdma_ig #(
  parameter int mem_aw = 64
) (
  input  logic                                    nvdla_core_clk,
  input  logic                                    nvdla_core_rstn,
  input  logic                                    op_load,
  input  logic                                    op_en,
  input  logic                                    perf_dma_en,
  input  sdp_rdma_pkg::cube_cfg_t                 cube_cfg,
  input  logic [31:0]                             base_addr_high,
  input  logic [31:0]                             base_addr_low,
  input  logic [31-sdp_rdma_pkg::atom_aw:0]       line_stride,
  input  logic [31-sdp_rdma_pkg::atom_aw:0]       surf_stride,
  input  logic                                    dma_rd_req_rdy,
  input  logic                                    cq_rdy,
  output logic                                    dma_rd_req_vld,
  output logic [mem_aw-1:0]                       dma_rd_req_addr,
  output logic [sdp_rdma_pkg::req_size_w-1:0]     dma_rd_req_size,
  output logic                                    cq_vld,
  output sdp_rdma_pkg::cq_req_t                   cq_pd,
  output logic [31:0]                             rdma_stall
);

  logic                                   cmd_process;
  logic                                   cmd_accept;
  logic                                   surf_end;
  logic                                   cube_end;
  logic                                   straight_mode;
  logic [sdp_rdma_pkg::chan_cnt_w-1:0]    chan_last;
  logic [sdp_rdma_pkg::req_size_w-1:0]    req_size;

  // ======================================================================
  // paired handshake
  // ======================================================================

  // each side only asks when the other side can take it too
  assign dma_rd_req_vld = cmd_process & cq_rdy;
  assign cq_vld         = cmd_process & dma_rd_req_rdy;
  // both sides move in the same cycle
  assign cmd_accept     = dma_rd_req_vld & dma_rd_req_rdy;

  // payload, same size on both sides
  assign dma_rd_req_size = req_size;
  assign cq_pd.cube_end  = cube_end;
  assign cq_pd.size      = req_size;

  // ======================================================================
  // sub blocks
  // ======================================================================

  cube_walker u_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .cube_cfg        (cube_cfg),
    .chan_last       (chan_last),
    .cmd_process     (cmd_process),
    .surf_end        (surf_end),
    .cube_end        (cube_end),
    .straight_mode   (straight_mode)
  );

  req_addr_gen #(
    .mem_aw (mem_aw)
  ) u_addr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .surf_end        (surf_end),
    .base_addr_high  (base_addr_high),
    .base_addr_low   (base_addr_low),
    .line_stride     (line_stride),
    .surf_stride     (surf_stride),
    .req_addr        (dma_rd_req_addr)
  );

  req_size_calc u_size (
    .cube_cfg      (cube_cfg),
    .straight_mode (straight_mode),
    .chan_last     (chan_last),
    .req_size      (req_size)
  );

  // stall = request offered to dma but not taken
  stall_counter u_stall (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .stall           (dma_rd_req_vld & ~dma_rd_req_rdy),
    .count_en        (op_en & perf_dma_en),
    .count           (rdma_stall)
  );

endmodule

/* sim/sdp_rdma_ig_properties.sv */
// concurrent checks on the request generator, bound into every
// sdp_rdma_ig instance: paired accepts, op done and config legality

module sdp_rdma_ig_properties (
  input logic                    nvdla_core_clk,
  input logic                    nvdla_core_rstn,
  input logic                    op_load,
  input logic                    op_en,
  input sdp_rdma_pkg::cube_cfg_t cube_cfg,
  input logic                    cmd_process,
  input logic                    cube_end,
  input logic                    dma_rd_req_vld,
  input logic                    dma_rd_req_rdy,
  input logic                    cq_vld,
  input logic                    cq_rdy
);

  logic dma_take;
  logic cq_take;

  assign dma_take = dma_rd_req_vld & dma_rd_req_rdy;
  assign cq_take  = cq_vld & cq_rdy;

  // ======================================================================
  // handshake
  // ======================================================================

  // dma and context queue always move together
  pair_a: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_take == cq_take) else $error("dma and context queue accepts split apart");

  // cube end only inside an active operation
  end_active_a: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_take && cube_end) |-> cmd_process) else $error("cube end accepted while idle");

  // op done drops the active flag
  op_done_a: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_take && cube_end && !op_load) |=> !cmd_process)
    else $error("operation still active after cube end");

  // ======================================================================
  // config
  // ======================================================================

  // 16-bit precisions need 2-byte data
  cfg_a: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    op_en |-> !(cube_cfg.data_size == sdp_rdma_pkg::size_1byte &&
                cube_cfg.precision != sdp_rdma_pkg::prec_int8))
    else $error("1-byte data with a 16-bit precision");

endmodule

bind sdp_rdma_ig sdp_rdma_ig_properties props_i (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .op_load         (op_load),
  .op_en           (op_en),
  .cube_cfg        (cube_cfg),
  .cmd_process     (cmd_process),
  .cube_end        (cube_end),
  .dma_rd_req_vld  (dma_rd_req_vld),
  .dma_rd_req_rdy  (dma_rd_req_rdy),
  .cq_vld          (cq_vld),
  .cq_rdy          (cq_rdy)
);

/* sim/tb_sdp_rdma_ig.sv */
// testbench for the sdp read dma request generator
// walks a table of cube configs, checks every accepted request against
// a reference walk and tracks the stall counter cycle by cycle

module tb_sdp_rdma_ig;

  localparam int mem_aw = 64;
  localparam int n_rows = 8;

  // one operation of the test table
  typedef struct packed {
    sdp_rdma_pkg::cube_cfg_t cfg;
    logic [31:0]             base_hi;
    logic [31:0]             base_lo;
    logic [26:0]             line_stride;
    logic [26:0]             surf_stride;
    logic                    op_en;
    logic                    perf_en;
    logic [6:0]              drop_pct;
    logic [15:0]             exp_reqs;
  } row_t;

  logic                    nvdla_core_clk;
  logic                    nvdla_core_rstn;
  logic                    op_load;
  logic                    op_en;
  logic                    perf_dma_en;
  sdp_rdma_pkg::cube_cfg_t cube_cfg;
  logic [31:0]             base_addr_high;
  logic [31:0]             base_addr_low;
  logic [26:0]             line_stride;
  logic [26:0]             surf_stride;
  logic                    dma_rd_req_rdy;
  logic                    cq_rdy;
  logic                    dma_rd_req_vld;
  logic [mem_aw-1:0]       dma_rd_req_addr;
  logic [14:0]             dma_rd_req_size;
  logic                    cq_vld;
  sdp_rdma_pkg::cq_req_t   cq_pd;
  logic [31:0]             rdma_stall;

  row_t        rows [n_rows];
  logic [63:0] exp_addr [$];
  logic [14:0] exp_size [$];
  logic        exp_end [$];
  int          idx;
  logic        pending;
  logic [31:0] stall_exp;
  integer      seed;
  int          cycle_cnt = 0;
  int          cycle_limit;

  sdp_rdma_ig #(
    .mem_aw (mem_aw)
  ) dut_i (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .op_en           (op_en),
    .perf_dma_en     (perf_dma_en),
    .cube_cfg        (cube_cfg),
    .base_addr_high  (base_addr_high),
    .base_addr_low   (base_addr_low),
    .line_stride     (line_stride),
    .surf_stride     (surf_stride),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .cq_rdy          (cq_rdy),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_addr (dma_rd_req_addr),
    .dma_rd_req_size (dma_rd_req_size),
    .cq_vld          (cq_vld),
    .cq_pd           (cq_pd),
    .rdma_stall      (rdma_stall)
  );

  // ======================================================================
  // helpers
  // ======================================================================

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else
      stop_run($sformatf("mismatch %s got 0x%0h exp 0x%0h", name, got, exp));
  endtask

  function automatic sdp_rdma_pkg::cube_cfg_t mk_cfg(
    input int ch, input int h, input int w,
    input sdp_rdma_pkg::precision_e prec, input sdp_rdma_pkg::data_mode_e mode,
    input sdp_rdma_pkg::data_size_e dsz, input sdp_rdma_pkg::data_use_e duse
  );
    sdp_rdma_pkg::cube_cfg_t c;
    c.channel   = sdp_rdma_pkg::dim_w'(ch);
    c.height    = sdp_rdma_pkg::dim_w'(h);
    c.width     = sdp_rdma_pkg::dim_w'(w);
    c.precision = prec;
    c.data_mode = mode;
    c.data_size = dsz;
    c.data_use  = duse;
    return c;
  endfunction

  function automatic row_t mk_row(
    input sdp_rdma_pkg::cube_cfg_t cfg, input logic [31:0] hi, input logic [31:0] lo,
    input logic [26:0] ls, input logic [26:0] ss,
    input int en, input int perf, input int pct, input int reqs
  );
    row_t r;
    r.cfg         = cfg;
    r.base_hi     = hi;
    r.base_lo     = lo;
    r.line_stride = ls;
    r.surf_stride = ss;
    r.op_en       = 1'(en);
    r.perf_en     = 1'(perf);
    r.drop_pct    = 7'(pct);
    r.exp_reqs    = 16'(reqs);
    return r;
  endfunction

  // ======================================================================
  // test table
  // ======================================================================

  task automatic fill_table();
    sdp_rdma_pkg::cube_cfg_t cfg;
    // per element, int8 2-byte both, 2 atoms x 3 lines; then the same under drops
    cfg = mk_cfg(63, 2, 7, sdp_rdma_pkg::prec_int8, sdp_rdma_pkg::mode_per_element,
                 sdp_rdma_pkg::size_2byte, sdp_rdma_pkg::use_both);
    rows[0] = mk_row(cfg, 32'h1, 32'h0001_0047, 27'h10, 27'h100, 1, 1, 0, 6);
    rows[1] = mk_row(cfg, 32'h1, 32'h0001_0047, 27'h10, 27'h100, 1, 1, 30, 6);
    // per kernel int8, stall count cleared here
    cfg = mk_cfg(95, 3, 5, sdp_rdma_pkg::prec_int8, sdp_rdma_pkg::mode_per_kernel,
                 sdp_rdma_pkg::size_1byte, sdp_rdma_pkg::use_mul);
    rows[2] = mk_row(cfg, 32'h0, 32'h0000_2000, 27'h1, 27'h2, 1, 1, 0, 1);
    // 1x1 pack int16
    cfg = mk_cfg(47, 0, 0, sdp_rdma_pkg::prec_int16, sdp_rdma_pkg::mode_per_element,
                 sdp_rdma_pkg::size_2byte, sdp_rdma_pkg::use_both);
    rows[3] = mk_row(cfg, 32'h0, 32'h0000_4020, 27'h5, 27'h9, 1, 1, 0, 1);
    // per kernel int16
    cfg = mk_cfg(31, 4, 3, sdp_rdma_pkg::prec_int16, sdp_rdma_pkg::mode_per_kernel,
                 sdp_rdma_pkg::size_2byte, sdp_rdma_pkg::use_alu);
    rows[4] = mk_row(cfg, 32'h3, 32'hffff_ffe0, 27'h7, 27'h70, 1, 1, 0, 1);
    // 1x1 pack int8
    cfg = mk_cfg(64, 0, 0, sdp_rdma_pkg::prec_int8, sdp_rdma_pkg::mode_per_element,
                 sdp_rdma_pkg::size_2byte, sdp_rdma_pkg::use_mul);
    rows[5] = mk_row(cfg, 32'h0, 32'h0000_0100, 27'h1, 27'h1, 1, 1, 0, 1);
    // fp16 walk with drops, counter running
    cfg = mk_cfg(31, 3, 4, sdp_rdma_pkg::prec_fp16, sdp_rdma_pkg::mode_per_element,
                 sdp_rdma_pkg::size_2byte, sdp_rdma_pkg::use_alu);
    rows[6] = mk_row(cfg, 32'h0, 32'h8000_0000, 27'h40, 27'h400, 1, 1, 30, 8);
    // drops with counting off, stall value must hold
    cfg = mk_cfg(40, 1, 9, sdp_rdma_pkg::prec_int8, sdp_rdma_pkg::mode_per_element,
                 sdp_rdma_pkg::size_1byte, sdp_rdma_pkg::use_mul);
    rows[7] = mk_row(cfg, 32'h2, 32'h1234_5660, 27'h3, 27'h7ff_ffff, 1, 0, 30, 4);
  endtask

  // ======================================================================
  // reference walk
  // ======================================================================

  // nested surface/line walk, one entry per expected request
  function automatic void build_walk(input row_t row);
    logic [63:0] base;
    logic [63:0] off;
    logic        straight;
    int          chan_n;
    int          scale;
    int          n;
    exp_addr.delete();
    exp_size.delete();
    exp_end.delete();
    base = {row.base_hi, row.base_lo} >> 5;
    straight = (row.cfg.data_mode == sdp_rdma_pkg::mode_per_kernel) ||
               (row.cfg.width == '0 && row.cfg.height == '0);
    if (row.cfg.precision == sdp_rdma_pkg::prec_int8) begin
      chan_n = int'(row.cfg.channel) / 32;
      scale  = (row.cfg.data_size == sdp_rdma_pkg::size_2byte) ? 2 : 1;
      scale  = (row.cfg.data_use == sdp_rdma_pkg::use_both) ? scale * 2 : scale;
    end else begin
      chan_n = int'(row.cfg.channel) / 16;
      scale  = (row.cfg.data_use == sdp_rdma_pkg::use_both) ? 2 : 1;
    end
    n = straight ? chan_n : int'(row.cfg.width);
    if (straight) begin
      exp_addr.push_back(base << 5);
      exp_size.push_back(15'(n * scale + scale - 1));
      exp_end.push_back(1'b1);
    end else begin
      for (int c = 0; c <= chan_n; c++) begin
        for (int h = 0; h <= int'(row.cfg.height); h++) begin
          off = 64'(c) * 64'(row.surf_stride) + 64'(h) * 64'(row.line_stride);
          exp_addr.push_back((base + off) << 5);
          exp_size.push_back(15'(n * scale + scale - 1));
          exp_end.push_back(c == chan_n && h == int'(row.cfg.height));
        end
      end
    end
  endfunction

  // ======================================================================
  // per cycle driving and checking
  // ======================================================================

  task automatic drive_readies(input int pct);
    int r_dma;
    int r_cq;
    r_dma = int'({$random(seed)} % 100);
    r_cq  = int'({$random(seed)} % 100);
    dma_rd_req_rdy <= (r_dma >= pct);
    cq_rdy         <= (r_cq >= pct);
  endtask

  // called mid cycle, outputs and driven readies are settled
  task automatic check_cycle();
    logic exp_vld;
    logic exp_cqv;
    exp_vld = pending & cq_rdy;
    exp_cqv = pending & dma_rd_req_rdy;
    check_val("dma_rd_req_vld", 64'(dma_rd_req_vld), 64'(exp_vld));
    check_val("cq_vld", 64'(cq_vld), 64'(exp_cqv));
    check_val("rdma_stall", 64'(rdma_stall), 64'(stall_exp));
    if (exp_vld && dma_rd_req_rdy) begin
      check_val("dma_rd_req_addr", dma_rd_req_addr, exp_addr[idx]);
      check_val("dma_rd_req_size", 64'(dma_rd_req_size), 64'(exp_size[idx]));
      check_val("cq_pd.size", 64'(cq_pd.size), 64'(exp_size[idx]));
      check_val("cq_pd.cube_end", 64'(cq_pd.cube_end), 64'(exp_end[idx]));
      idx = idx + 1;
      if (idx == exp_addr.size()) begin
        pending = 1'b0;
      end
    end
    // stall model, counter moves on the following edge
    if (op_en && perf_dma_en) begin
      if (op_load) begin
        stall_exp = '0;
      end else if (exp_vld && !dma_rd_req_rdy) begin
        stall_exp = stall_exp + 1;
      end
    end
  endtask

  // ======================================================================
  // clock, timeout, main sequence
  // ======================================================================

  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_run("timeout: the request walk did not finish within the cycle limit");
    end
  end

  initial begin
    seed            = 91;
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    op_en           = 1'b0;
    perf_dma_en     = 1'b0;
    cube_cfg        = mk_cfg(0, 0, 0, sdp_rdma_pkg::prec_int8, sdp_rdma_pkg::mode_per_kernel,
                             sdp_rdma_pkg::size_1byte, sdp_rdma_pkg::use_mul);
    base_addr_high  = '0;
    base_addr_low   = '0;
    line_stride     = '0;
    surf_stride     = '0;
    dma_rd_req_rdy  = 1'b1;
    cq_rdy          = 1'b1;
    pending         = 1'b0;
    idx             = 0;
    stall_exp       = '0;
    fill_table();
    // four cycles per request worst case plus slack for row overhead
    cycle_limit = 200;
    foreach (rows[r]) begin
      cycle_limit = cycle_limit + 4 * int'(rows[r].exp_reqs);
    end
    repeat (4) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    // idle before any op_load, nothing may be offered
    repeat (5) begin
      @(negedge nvdla_core_clk);
      check_cycle();
      @(posedge nvdla_core_clk);
      drive_readies(30);
    end
    foreach (rows[r]) begin
      build_walk(rows[r]);
      check_val("expected request count", 64'(exp_addr.size()), 64'(rows[r].exp_reqs));
      idx = 0;
      cube_cfg       <= rows[r].cfg;
      base_addr_high <= rows[r].base_hi;
      base_addr_low  <= rows[r].base_lo;
      line_stride    <= rows[r].line_stride;
      surf_stride    <= rows[r].surf_stride;
      op_en          <= rows[r].op_en;
      perf_dma_en    <= rows[r].perf_en;
      op_load        <= 1'b1;
      @(negedge nvdla_core_clk);
      check_cycle();
      @(posedge nvdla_core_clk);
      op_load <= 1'b0;
      drive_readies(int'(rows[r].drop_pct));
      pending = 1'b1;
      while (pending) begin
        @(negedge nvdla_core_clk);
        check_cycle();
        @(posedge nvdla_core_clk);
        drive_readies(int'(rows[r].drop_pct));
      end
      // cmd_process has dropped after the cube end accept
      @(negedge nvdla_core_clk);
      check_cycle();
      @(posedge nvdla_core_clk);
    end
    repeat (3) begin
      @(negedge nvdla_core_clk);
      check_cycle();
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* src.f */
common/sdp_rdma_pkg.sv
logic/stall_counter.sv
sdp_rdma_ig/cube_walker.sv
sdp_rdma_ig/req_addr_gen.sv
sdp_rdma_ig/req_size_calc.sv
sdp_rdma_ig/sdp_rdma_ig.sv
sim/sdp_rdma_ig_properties.sv
sim/tb_sdp_rdma_ig.sv
